/* src/rv_decode_pkg.sv */
package rv_decode_pkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes, instr[6:2]
    localparam logic [4:0] OPC_LD   = 5'b00000;
    localparam logic [4:0] OPC_ARI  = 5'b00100;
    localparam logic [4:0] OPC_AUI  = 5'b00101;
    localparam logic [4:0] OPC_STR  = 5'b01000;
    localparam logic [4:0] OPC_ARR  = 5'b01100;
    localparam logic [4:0] OPC_LUI  = 5'b01101;
    localparam logic [4:0] OPC_B    = 5'b11000;
    localparam logic [4:0] OPC_JALR = 5'b11001;
    localparam logic [4:0] OPC_JAL  = 5'b11011;
    localparam logic [4:0] OPC_SYS  = 5'b11100;

    // instr[1:0] of a 32-bit encoding
    localparam logic [1:0] OPC_FULL = 2'b11;

    localparam logic [6:0]  F7_BASE    = 7'b0000000;
    localparam logic [6:0]  F7_ALT     = 7'b0100000;
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;

    localparam funct3_t FUNCT3_DEFAULT = 3'b010;
    localparam word_t   PC_STEP        = 32'd4;

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_LUI,
        CLS_AUIPC,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_SYSTEM,
        CLS_ILLEGAL
    } instr_class_e;

    // item between stage one and stage two
    typedef struct packed {
        logic         valid;
        word_t        instr;
        word_t        pc;
        instr_class_e cls;
        logic         supported;
    } class_item_t;

    // one-hot result group of the ALU
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_grp_t;

    typedef struct packed {
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inv;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic shl;
        logic shr;
        logic sub;
        logic add;
        logic shr_arith;
    } alu_ctrl_t;

    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic pc;
        logic r;
    } op1_src_t;

    typedef struct packed {
        logic j;
        logic imm;
        logic r;
    } op2_src_t;

    typedef struct packed {
        word_t     pc;
        word_t     pc_next;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm_i;
        word_t     imm_j;
        funct3_t   funct3;
        alu_grp_t  alu_grp;
        alu_ctrl_t alu_ctrl;
        res_src_t  res_src;
        op1_src_t  op1_src;
        op2_src_t  op2_src;
        logic      reg_write;
        logic      is_jal;
        logic      is_jalr;
        logic      is_branch;
        logic      is_store;
        logic      supported;
    } dec_out_t;

endpackage

/* src/rv_classify_stage.sv */
`timescale 1ns/1ps

module rv_classify_stage
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_valid,
    input  logic                       i_stall,
    input  logic                       i_flush,
    input  rv_decode_pkg::word_t       i_instruction,
    input  rv_decode_pkg::word_t       i_pc,
    output rv_decode_pkg::class_item_t o_item
);
    import rv_decode_pkg::*;

    logic [4:0]   opc;
    funct3_t      f3;
    logic [6:0]   f7;
    logic [11:0]  f12;
    instr_class_e cls;
    logic         supported;

    logic         valid_q;
    word_t        instr_q;
    word_t        pc_q;
    instr_class_e cls_q;
    logic         supported_q;

    assign opc = i_instruction[6:2];
    assign f3  = i_instruction[14:12];
    assign f7  = i_instruction[31:25];
    assign f12 = i_instruction[31:20];

    // anything not matched below stays illegal
    always_comb
    begin
        cls = CLS_ILLEGAL;
        if (i_instruction == '0)
            cls = CLS_NONE;
        else if (i_instruction[1:0] == OPC_FULL)
        begin
            case (opc)
                OPC_LD:
                    if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                        cls = CLS_LOAD;
                OPC_STR:
                    if (f3 inside {3'b000, 3'b001, 3'b010})
                        cls = CLS_STORE;
                OPC_ARI:
                begin
                    // shifts by immediate check funct7
                    if ((f3 == 3'b001 && f7 == F7_BASE) ||
                        (f3 == 3'b101 && (f7 == F7_BASE || f7 == F7_ALT)) ||
                        (f3 != 3'b001 && f3 != 3'b101))
                        cls = CLS_OP_IMM;
                end
                OPC_ARR:
                begin
                    // alt funct7 only for sub and sra
                    if (f7 == F7_BASE || (f7 == F7_ALT && (f3 == 3'b000 || f3 == 3'b101)))
                        cls = CLS_OP;
                end
                OPC_LUI:  cls = CLS_LUI;
                OPC_AUI:  cls = CLS_AUIPC;
                OPC_B:
                    if (f3 != 3'b010 && f3 != 3'b011)
                        cls = CLS_BRANCH;
                OPC_JAL:  cls = CLS_JAL;
                OPC_JALR:
                    if (f3 == 3'b000)
                        cls = CLS_JALR;
                OPC_SYS:
                    if (f3 == 3'b000 && (f12 == F12_ECALL || f12 == F12_EBREAK))
                        cls = CLS_SYSTEM;
                default:  cls = CLS_ILLEGAL;
            endcase
        end
    end

    assign supported = (cls != CLS_ILLEGAL);

    // flush wins over stall
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
            valid_q <= 1'b0;
        else if (!i_stall)
            valid_q <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall && i_valid)
        begin
            instr_q     <= i_instruction;
            pc_q        <= i_pc;
            cls_q       <= cls;
            supported_q <= supported;
        end
    end

    assign o_item = '{valid: valid_q, instr: instr_q, pc: pc_q, cls: cls_q,
                      supported: supported_q};

    // a held item stays put while stalled
    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_item.valid && i_stall && !i_flush) |=> (o_item.valid && $stable(o_item)));

endmodule

/* src/rv_imm_gen.sv */
`timescale 1ns/1ps

module rv_imm_gen
(
    input  rv_decode_pkg::word_t i_instr,
    output rv_decode_pkg::word_t o_imm_i,
    output rv_decode_pkg::word_t o_imm_s,
    output rv_decode_pkg::word_t o_imm_b,
    output rv_decode_pkg::word_t o_imm_u,
    output rv_decode_pkg::word_t o_imm_j
);

    // all formats take the sign from bit 31
    assign o_imm_i = {{21{i_instr[31]}}, i_instr[30:20]};

    assign o_imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};

    // branch offsets are halfword aligned
    assign o_imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                      i_instr[11:8], 1'b0};

    assign o_imm_u = {i_instr[31:12], 12'b0};

    assign o_imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                      i_instr[30:21], 1'b0};

endmodule

/* src/rv_control_stage.sv */
`timescale 1ns/1ps

module rv_control_stage
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_stall,
    input  logic                       i_flush,
    input  rv_decode_pkg::class_item_t i_item,
    output logic                       o_valid,
    output rv_decode_pkg::dec_out_t    o_dec
);
    import rv_decode_pkg::*;

    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_u;
    word_t    imm_j;
    funct3_t  f3;
    logic     f7_alt;
    logic     is_load;
    logic     is_store;
    logic     is_op_imm;
    logic     is_op;
    logic     is_lui;
    logic     is_auipc;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     is_sys;
    logic     known;
    logic     alu_rx;
    logic     use_imm;
    dec_out_t dec_d;
    logic     valid_q;
    dec_out_t dec_q;

    rv_imm_gen u_imm_gen
    (
        .i_instr (i_item.instr),
        .o_imm_i (imm_i),
        .o_imm_s (imm_s),
        .o_imm_b (imm_b),
        .o_imm_u (imm_u),
        .o_imm_j (imm_j)
    );

    assign f3        = i_item.instr[14:12];
    assign f7_alt    = i_item.instr[30];
    assign is_load   = (i_item.cls == CLS_LOAD);
    assign is_store  = (i_item.cls == CLS_STORE);
    assign is_op_imm = (i_item.cls == CLS_OP_IMM);
    assign is_op     = (i_item.cls == CLS_OP);
    assign is_lui    = (i_item.cls == CLS_LUI);
    assign is_auipc  = (i_item.cls == CLS_AUIPC);
    assign is_branch = (i_item.cls == CLS_BRANCH);
    assign is_jal    = (i_item.cls == CLS_JAL);
    assign is_jalr   = (i_item.cls == CLS_JALR);
    assign is_sys    = (i_item.cls == CLS_SYSTEM);

    // real instruction, not the none word and not illegal
    assign known   = |{is_load, is_store, is_op_imm, is_op, is_lui, is_auipc,
                       is_branch, is_jal, is_jalr, is_sys};
    assign alu_rx  = is_op_imm | is_op;
    assign use_imm = |{is_jalr, is_load, is_op_imm, is_lui, is_auipc, is_store};

    always_comb
    begin
        dec_d          = '0;
        dec_d.pc       = i_item.pc;
        dec_d.pc_next  = i_item.pc + PC_STEP;
        dec_d.rd       = i_item.instr[11:7];
        dec_d.rs1      = is_lui ? '0 : i_item.instr[19:15];
        dec_d.rs2      = i_item.instr[24:20];
        dec_d.imm_i    = (is_lui | is_auipc) ? imm_u : (is_store ? imm_s : imm_i);
        dec_d.imm_j    = is_jal ? imm_j : imm_b;
        dec_d.funct3   = (i_item.instr[1:0] == OPC_FULL) ? f3 : FUNCT3_DEFAULT;

        dec_d.alu_grp.cmp   = is_branch | (alu_rx & f3[2:1] == 2'b01);
        dec_d.alu_grp.bits  = alu_rx & (f3 inside {3'b100, 3'b110, 3'b111});
        dec_d.alu_grp.shift = alu_rx & (f3[1:0] == 2'b01);
        // addi stays outside the arith group
        dec_d.alu_grp.arith = (is_op & f3 == 3'b000) | is_load | is_store;

        dec_d.alu_ctrl.cmp_eq    = is_branch & (f3[2:1] == 2'b00);
        dec_d.alu_ctrl.cmp_lts   = (alu_rx & f3 == 3'b010) | (is_branch & f3[2:1] == 2'b10);
        dec_d.alu_ctrl.cmp_ltu   = (alu_rx & f3 == 3'b011) | (is_branch & f3[2:1] == 2'b11);
        dec_d.alu_ctrl.cmp_inv   = is_branch & f3[0];
        dec_d.alu_ctrl.bits_and  = alu_rx & (f3 == 3'b111);
        dec_d.alu_ctrl.bits_or   = alu_rx & (f3 == 3'b110);
        dec_d.alu_ctrl.bits_xor  = alu_rx & (f3 == 3'b100);
        dec_d.alu_ctrl.shl       = alu_rx & (f3 == 3'b001);
        dec_d.alu_ctrl.shr       = alu_rx & (f3 == 3'b101);
        dec_d.alu_ctrl.sub       = is_op & (f3 == 3'b000) & f7_alt;
        dec_d.alu_ctrl.add       = (is_op & f3 == 3'b000 & !f7_alt) |
                                   (is_op_imm & f3 == 3'b000) | is_load | is_store;
        dec_d.alu_ctrl.shr_arith = alu_rx & (f3 == 3'b101) & f7_alt;

        dec_d.res_src.memory  = is_load;
        dec_d.res_src.pc_next = is_jal | is_jalr;
        dec_d.res_src.alu     = known & !(is_load | is_jal | is_jalr);
        dec_d.op1_src.pc      = is_auipc | is_jal;
        dec_d.op1_src.r       = known & !(is_auipc | is_jal);
        dec_d.op2_src.j       = is_jal;
        dec_d.op2_src.imm     = use_imm;
        dec_d.op2_src.r       = known & !(is_jal | use_imm);

        dec_d.reg_write = |{is_load, is_op_imm, is_op, is_lui, is_auipc, is_jal, is_jalr};
        dec_d.is_jal    = is_jal;
        dec_d.is_jalr   = is_jalr;
        dec_d.is_branch = is_branch;
        dec_d.is_store  = is_store;
        dec_d.supported = i_item.supported;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
            valid_q <= 1'b0;
        else if (!i_stall)
            valid_q <= i_item.valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall && i_item.valid)
            dec_q <= dec_d;
    end

    assign o_valid = valid_q;
    assign o_dec   = dec_q;

    a_grp_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |-> $onehot0(o_dec.alu_grp));

    // writes only come from classes stage one accepted
    a_write_supported: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && o_dec.reg_write) |-> o_dec.supported);

endmodule

/* src/rv_decode_top.sv */
`timescale 1ns/1ps

module rv_decode_top
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  rv_decode_pkg::word_t    i_instruction,
    input  rv_decode_pkg::word_t    i_pc,
    input  logic                    i_stall,
    input  logic                    i_flush,
    output logic                    o_valid,
    output rv_decode_pkg::dec_out_t o_dec
);
    import rv_decode_pkg::*;

    class_item_t item;

    rv_classify_stage u_classify
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .o_item        (item)
    );

    rv_control_stage u_control
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_item  (item),
        .o_valid (o_valid),
        .o_dec   (o_dec)
    );

endmodule

/* sim/tb_rv_decode_ref.svh */
`ifndef TB_RV_DECODE_REF_SVH
`define TB_RV_DECODE_REF_SVH

// class of a word from the RV32I encoding rules
function automatic instr_class_e ref_class(input word_t w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    if (w == 32'h0)
        return CLS_NONE;
    if (w[1:0] != 2'b11)
        return CLS_ILLEGAL;
    case (w[6:2])
        OPC_LD:   return (f3 == 3'd3 || f3 > 3'd5) ? CLS_ILLEGAL : CLS_LOAD;
        OPC_STR:  return (f3 < 3'd3) ? CLS_STORE : CLS_ILLEGAL;
        OPC_ARI:
        begin
            if (f3 == 3'd1)
                return (f7 == 7'h00) ? CLS_OP_IMM : CLS_ILLEGAL;
            if (f3 == 3'd5)
                return (f7 == 7'h00 || f7 == 7'h20) ? CLS_OP_IMM : CLS_ILLEGAL;
            return CLS_OP_IMM;
        end
        OPC_ARR:
        begin
            if (f7 == 7'h00)
                return CLS_OP;
            // sub and sra
            return (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) ? CLS_OP : CLS_ILLEGAL;
        end
        OPC_LUI:  return CLS_LUI;
        OPC_AUI:  return CLS_AUIPC;
        OPC_B:    return (f3 == 3'd2 || f3 == 3'd3) ? CLS_ILLEGAL : CLS_BRANCH;
        OPC_JALR: return (f3 == 3'd0) ? CLS_JALR : CLS_ILLEGAL;
        OPC_JAL:  return CLS_JAL;
        OPC_SYS:
            return (f3 == 3'd0 && (w[31:20] == 12'h000 || w[31:20] == 12'h001)) ?
                   CLS_SYSTEM : CLS_ILLEGAL;
        default:  return CLS_ILLEGAL;
    endcase
endfunction

// expected decoded output of one word at a given pc
function automatic dec_out_t ref_decode(input word_t w, input word_t pc);
    dec_out_t     d;
    instr_class_e c;
    logic [2:0]   f3;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_b;
    word_t        imm_u;
    word_t        imm_j;
    c     = ref_class(w);
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    d = '0;
    d.pc        = pc;
    d.pc_next   = pc + 32'd4;
    d.rd        = w[11:7];
    d.rs1       = (c == CLS_LUI) ? 5'd0 : w[19:15];
    d.rs2       = w[24:20];
    d.imm_i     = (c == CLS_LUI || c == CLS_AUIPC) ? imm_u :
                  ((c == CLS_STORE) ? imm_s : imm_i);
    d.imm_j     = (c == CLS_JAL) ? imm_j : imm_b;
    d.funct3    = (w[1:0] == 2'b11) ? f3 : 3'b010;
    d.supported = (c != CLS_ILLEGAL);
    case (c)
        CLS_LOAD:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b100, 2'b01, 3'b010};
            {d.reg_write, d.alu_grp, d.alu_ctrl} = {1'b1, 4'b0001, 12'h002};
        end
        CLS_STORE:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b001, 2'b01, 3'b010};
            {d.is_store, d.alu_grp, d.alu_ctrl} = {1'b1, 4'b0001, 12'h002};
        end
        CLS_LUI:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b001, 2'b01, 3'b010};
            d.reg_write = 1'b1;
        end
        CLS_AUIPC:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b001, 2'b10, 3'b010};
            d.reg_write = 1'b1;
        end
        CLS_JAL:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b010, 2'b10, 3'b100};
            {d.reg_write, d.is_jal} = 2'b11;
        end
        CLS_JALR:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b010, 2'b01, 3'b010};
            {d.reg_write, d.is_jalr} = 2'b11;
        end
        CLS_SYSTEM: {d.res_src, d.op1_src, d.op2_src} = {3'b001, 2'b01, 3'b001};
        CLS_BRANCH:
        begin
            {d.res_src, d.op1_src, d.op2_src} = {3'b001, 2'b01, 3'b001};
            {d.is_branch, d.alu_grp} = {1'b1, 4'b1000};
            d.alu_ctrl.cmp_eq  = (f3[2:1] == 2'b00);
            d.alu_ctrl.cmp_lts = (f3[2:1] == 2'b10);
            d.alu_ctrl.cmp_ltu = (f3[2:1] == 2'b11);
            d.alu_ctrl.cmp_inv = f3[0];
        end
        CLS_OP, CLS_OP_IMM:
        begin
            d.reg_write       = 1'b1;
            d.res_src.alu     = 1'b1;
            d.op1_src.r       = 1'b1;
            d.op2_src.imm     = (c == CLS_OP_IMM);
            d.op2_src.r       = (c == CLS_OP);
            case (f3)
                3'd0:
                begin
                    // only the register form belongs to the arith group
                    d.alu_grp.arith = (c == CLS_OP);
                    d.alu_ctrl.sub  = (c == CLS_OP) && w[30];
                    d.alu_ctrl.add  = !((c == CLS_OP) && w[30]);
                end
                3'd1: {d.alu_grp.shift, d.alu_ctrl.shl} = 2'b11;
                3'd2: {d.alu_grp.cmp, d.alu_ctrl.cmp_lts} = 2'b11;
                3'd3: {d.alu_grp.cmp, d.alu_ctrl.cmp_ltu} = 2'b11;
                3'd4: {d.alu_grp.bits, d.alu_ctrl.bits_xor} = 2'b11;
                3'd5: {d.alu_grp.shift, d.alu_ctrl.shr, d.alu_ctrl.shr_arith} = {2'b11, w[30]};
                3'd6: {d.alu_grp.bits, d.alu_ctrl.bits_or} = 2'b11;
                default: {d.alu_grp.bits, d.alu_ctrl.bits_and} = 2'b11;
            endcase
        end
        default: ;
    endcase
    return d;
endfunction

`endif

/* sim/tb_rv_decode.sv */
`timescale 1ns/1ps

module tb_rv_decode;
    import rv_decode_pkg::*;
    `include "tb_rv_decode_ref.svh"

    localparam int RESET_CYCLES  = 3;
    localparam int T1_CYCLES     = 20;
    localparam int T2_CYCLES     = 120;
    localparam int T3_CYCLES     = 320;
    localparam int T4_CYCLES     = 260;
    localparam int T5_CYCLES     = 50;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                   T4_CYCLES + T5_CYCLES;

    logic     i_clk;
    logic     i_reset;
    logic     i_valid;
    word_t    i_instruction;
    word_t    i_pc;
    logic     i_stall;
    logic     i_flush;
    logic     o_valid;
    dec_out_t o_dec;

    dec_out_t exp_q[$];
    dec_out_t exp_d;
    dec_out_t held;
    logic     last_upd;
    int       errors   = 0;
    int       checks   = 0;
    int       outputs  = 0;
    int       accepted = 0;
    integer   seed     = 32'hc873;
    word_t    pc_ctr   = 32'h0000_1000;

    rv_decode_top dut0
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .o_valid       (o_valid),
        .o_dec         (o_dec)
    );

    always #10 i_clk = ~i_clk;

    // expected items follow every accepted strobe
    always @(posedge i_clk)
    begin
        last_upd <= !i_stall;
        if (i_reset || i_flush)
            exp_q.delete();
        else if (i_valid && !i_stall)
        begin
            exp_q.push_back(ref_decode(i_instruction, i_pc));
            accepted++;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge i_clk)
    begin
        if (!i_reset && o_valid && last_upd)
        begin
            if (exp_q.size() == 0)
            begin
                $display("error at %0t: o_valid high with no item in flight", $time);
                errors++;
            end
            else
            begin
                exp_d = exp_q.pop_front();
                checks++;
                outputs++;
                assert (o_dec === exp_d)
                else
                begin
                    $display("[FAIL] %0t: pc %h got %h expected %h",
                             $time, exp_d.pc, o_dec, exp_d);
                    errors++;
                end
                held = o_dec;
            end
        end
        else if (!i_reset && o_valid)
        begin
            // stalled output must hold
            assert (o_dec === held)
            else
            begin
                $display("[FAIL] %0t: output changed during stall", $time);
                errors++;
            end
        end
    end

    task automatic drive(input logic v, input word_t w, input word_t p,
                         input logic st, input logic fl);
        @(posedge i_clk);
        #2;
        i_valid       = v;
        i_instruction = w;
        i_pc          = p;
        i_stall       = st;
        i_flush       = fl;
    endtask

    task automatic idle();
        drive(1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic send(input word_t w);
        drive(1'b1, w, pc_ctr, 1'b0, 1'b0);
        pc_ctr = pc_ctr + 32'd4;
    endtask

    function automatic word_t rand_pc();
        word_t r;
        r = $random(seed);
        return r & 32'hffff_fffc;
    endfunction

    function automatic word_t enc(input logic [11:0] top, input logic [2:0] f3,
                                  input logic [6:0] op);
        return {top, 5'd11, f3, 5'd6, op};
    endfunction

    // wait for the pipeline to empty, bounded
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 10)
        begin
            idle();
            n++;
        end
        idle();
        idle();
        assert (exp_q.size() == 0)
        else
        begin
            $display("[FAIL] %0t: %0d items never came out", $time, exp_q.size());
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset_latency();
        int e;
        e = errors;
        repeat (4)
        begin
            idle();
            @(negedge i_clk);
            assert (!o_valid)
            else
            begin
                $display("[FAIL] %0t: o_valid after reset", $time);
                errors++;
            end
        end
        send(enc(12'h8a5, 3'd0, 7'h13));
        idle();
        @(negedge i_clk);
        assert (!o_valid)
        else
        begin
            $display("[FAIL] %0t: output one cycle early", $time);
            errors++;
        end
        @(negedge i_clk);
        assert (o_valid)
        else
        begin
            $display("[FAIL] %0t: no output after 2 cycles", $time);
            errors++;
        end
        drain();
        report_test("reset and latency", e);
    endtask

    task automatic test_directed();
        int e;
        e = errors;
        for (int f = 0; f < 8; f++)
        begin
            send(enc(12'h8a5, 3'(f), 7'h03));
            send(enc(12'h7f3, 3'(f), 7'h23));
            send(enc({7'h00, 5'd7}, 3'(f), 7'h13));
            send(enc({7'h20, 5'd9}, 3'(f), 7'h13));
            send(enc({7'h00, 5'd3}, 3'(f), 7'h33));
            send(enc({7'h20, 5'd3}, 3'(f), 7'h33));
            send(enc({7'h01, 5'd3}, 3'(f), 7'h33));
            send(enc(12'hc41, 3'(f), 7'h63));
            send(enc(12'h123, 3'(f), 7'h67));
            send(enc(12'h000, 3'(f), 7'h73));
        end
        send(32'h0000_0073);
        send(32'h0010_0073);
        send(32'hfedc_b0b7);
        send(32'h8001_2197);
        send(32'h8ab4_d0ef);
        send(32'h0000_0000);
        send(32'h0000_0012);
        send(32'h1234_5679);
        send(32'h0020_007f);
        drain();
        report_test("directed", e);
    endtask

    task automatic test_random_stream();
        int e;
        int o;
        e = errors;
        o = outputs;
        repeat (300)
            drive(1'b1, $random(seed), rand_pc(), 1'b0, 1'b0);
        drain();
        assert (outputs - o == 300)
        else
        begin
            $display("[FAIL] %0t: %0d of 300 outputs", $time, outputs - o);
            errors++;
        end
        report_test("random stream", e);
    endtask

    task automatic test_random_stall();
        int    e;
        int    n;
        int    o;
        logic  st;
        word_t w;
        word_t p;
        e = errors;
        o = outputs;
        n = 0;
        w = $random(seed);
        p = rand_pc();
        while (n < 100)
        begin
            st = (($random(seed) & 3) == 0);
            drive(1'b1, w, p, st, 1'b0);
            if (!st)
            begin
                n++;
                w = $random(seed);
                p = rand_pc();
            end
        end
        drain();
        assert (outputs - o == 100)
        else
        begin
            $display("[FAIL] %0t: item count off under stall", $time);
            errors++;
        end
        report_test("random stall", e);
    endtask

    task automatic test_flush();
        int e;
        int o;
        e = errors;
        o = outputs;
        send(enc(12'h001, 3'd0, 7'h13));
        send(enc(12'h002, 3'd0, 7'h13));
        drive(1'b1, enc(12'h003, 3'd0, 7'h13), pc_ctr, 1'b0, 1'b1);
        drain();
        // only the first strobe was past both stages
        assert (outputs - o == 1)
        else
        begin
            $display("[FAIL] %0t: %0d outputs around flush", $time, outputs - o);
            errors++;
        end
        repeat (10)
            send($random(seed));
        drain();
        report_test("flush", e);
    endtask

    initial
    begin
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_valid       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        test_reset_latency();
        test_directed();
        test_random_stream();
        test_random_stall();
        test_flush();
        $display("accepted %0d, checks %0d, outputs %0d, errors %0d",
                 accepted, checks, outputs, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(TOTAL_CYCLES * 2 * 20);
        $display("timeout: the run went past its cycle budget");
        $display("Test failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+sim
src/rv_decode_pkg.sv
src/rv_classify_stage.sv
src/rv_imm_gen.sv
src/rv_control_stage.sv
src/rv_decode_top.sv
sim/tb_rv_decode.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
